//--- all.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_wb_reg.sv
hw/ex_stage.sv
verif/ex_stage_assert.sv
verif/ex_stage_tb.sv

//--- hw/ex_alu.sv
//////////////////////////////////////////////////
// Single-cycle integer ALU
// Add, subtract, logic, shifts, set-less-than
// Branch comparison flag for the six branch types
//////////////////////////////////////////////////

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  // Adder path
  logic          is_sub;
  ex_pkg::word_t adder_b;
  ex_pkg::word_t adder_result;

  // Comparator path
  logic          is_equal;
  logic          is_less_s;
  logic          is_less_u;

  // Shifter path
  logic [4:0]    shamt;
  ex_pkg::word_t shift_left;
  ex_pkg::word_t shift_right_l;
  ex_pkg::word_t shift_right_a;

  //////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////

  // Only SUB takes the two's complement of operand b
  assign is_sub       = (operator_i == ex_pkg::ALU_SUB);
  assign adder_b      = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result = operand_a_i + adder_b + {31'b0, is_sub};

  //////////////////////////////////////////////////
  // Comparisons
  //////////////////////////////////////////////////

  // Computed once, shared by SLT/SLTU and all branches
  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  always_comb begin
    unique case (operator_i)
      ex_pkg::ALU_EQ:                   cmp_result_o = is_equal;
      ex_pkg::ALU_NE:                   cmp_result_o = ~is_equal;
      ex_pkg::ALU_LT, ex_pkg::ALU_SLT:  cmp_result_o = is_less_s;
      ex_pkg::ALU_GE:                   cmp_result_o = ~is_less_s;
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: cmp_result_o = is_less_u;
      ex_pkg::ALU_GEU:                  cmp_result_o = ~is_less_u;
      default:                          cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////

  // Shift amount from the low five bits of operand b
  assign shamt         = operand_b_i[4:0];
  assign shift_left    = operand_a_i << shamt;
  assign shift_right_l = operand_a_i >> shamt;
  assign shift_right_a = $signed(operand_a_i) >>> shamt;

  // Result select
  always_comb begin
    unique case (operator_i)
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = shift_left;
      ex_pkg::ALU_SRL:  result_o = shift_right_l;
      ex_pkg::ALU_SRA:  result_o = shift_right_a;
      // Compare flag, zero-extended
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: result_o = {31'b0, cmp_result_o};
      // ADD, SUB and the branch operators give the sum
      default:          result_o = adder_result;
    endcase
  end

endmodule

//--- hw/ex_mult.sv
//////////////////////////////////////////////////
// Iterative 32x32 multiplier
// One operand b chunk per cycle into a 64-bit sum
// MUL, MULH, MULHSU and MULHU with valid/ready
//////////////////////////////////////////////////

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  ex_pkg::mul_op_e operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  logic            valid_i,
  input  logic            ready_i,
  output ex_pkg::word_t   result_o,
  output logic            ready_o,
  output logic            valid_o
);

  // Step counter and completion flag
  logic [$clog2(ex_pkg::MUL_STEPS)-1:0] cnt_q;
  logic                                 done_q;
  logic                                 last_step;

  // Operand signedness
  logic sign_a;
  logic sign_b;

  // Partial product datapath
  logic signed [32:0]                        a_ext;
  logic        [ex_pkg::MUL_CHUNK_W-1:0]     b_slice;
  logic signed [ex_pkg::MUL_CHUNK_W:0]       b_chunk;
  logic signed [32+ex_pkg::MUL_CHUNK_W+1:0]  pp;
  logic signed [63:0]                        pp_ext;
  logic signed [63:0]                        pp_shifted;
  ex_pkg::dword_t                            acc_q;
  ex_pkg::dword_t                            acc_base;

  // a is signed for MULH and MULHSU, b only for MULH
  // MUL takes the low word, which does not depend on signedness
  assign sign_a = (operator_i == ex_pkg::MUL_MULH) || (operator_i == ex_pkg::MUL_MULHSU);
  assign sign_b = (operator_i == ex_pkg::MUL_MULH);

  assign last_step = (cnt_q == ex_pkg::MUL_STEPS - 1);

  //////////////////////////////////////////////////
  // Partial product
  //////////////////////////////////////////////////

  always_comb begin
    a_ext   = {sign_a & op_a_i[31], op_a_i};
    b_slice = op_b_i[cnt_q*ex_pkg::MUL_CHUNK_W +: ex_pkg::MUL_CHUNK_W];
    // Top slice carries the negative weight for a signed b
    b_chunk = {sign_b & last_step & op_b_i[31], b_slice};
    pp      = a_ext * b_chunk;
    // Sign extend, then weight by the chunk position
    pp_ext     = pp;
    pp_shifted = pp_ext <<< (cnt_q * ex_pkg::MUL_CHUNK_W);
  end

  // First step starts from an empty sum
  assign acc_base = (cnt_q == '0) ? '0 : acc_q;

  // Accumulator, written on each active step
  always_ff @(posedge clk) begin
    if (valid_i && !done_q) begin
      acc_q <= acc_base + pp_shifted;
    end
  end

  //////////////////////////////////////////////////
  // Step control
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (!valid_i) begin
      // Killed or halted, drop the partial product
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (done_q) begin
      // Hold the result until the consumer takes it
      if (ready_i) begin
        done_q <= 1'b0;
        cnt_q  <= '0;
      end
    end else if (last_step) begin
      done_q <= 1'b1;
      cnt_q  <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Handshake
  assign valid_o = done_q;
  assign ready_o = !valid_i || (valid_o && ready_i);

  // Low word for MUL, high word otherwise
  assign result_o = (operator_i == ex_pkg::MUL_MUL) ? acc_q[31:0] : acc_q[63:32];

endmodule

//--- hw/ex_pkg.sv
//////////////////////////////////////////////////
// Shared types for the execute stage
// Data word, register address and accumulator types
// ALU and multiplier operator encodings
// Multiplier chunk width and step count
//////////////////////////////////////////////////

package ex_pkg;

  // Operand, result and program counter word
  typedef logic [31:0] word_t;

  // Register file address
  typedef logic [4:0] rf_addr_t;

  // Full product accumulator
  typedef logic [63:0] dword_t;

  // ALU operators, arithmetic and logic first, branch compares last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // Operand b bits consumed per multiplier cycle
  localparam int MUL_CHUNK_W = 8;
  // Accumulate cycles per multiply
  localparam int MUL_STEPS   = 32 / MUL_CHUNK_W;

endpackage

//--- hw/ex_stage.sv
//////////////////////////////////////////////////
// Execute stage top
// Kill/halt gating and write-data forwarding mux
// Stage ready/valid, ALU, multiplier, EX/WB register
//////////////////////////////////////////////////

module ex_stage (
  input  logic             clk,
  input  logic             rst_n,

  // From the issuing stage
  input  logic             instr_valid_i,
  input  logic             alu_en_i,
  input  logic             mul_en_i,
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::word_t    alu_operand_a_i,
  input  ex_pkg::word_t    alu_operand_b_i,
  input  ex_pkg::mul_op_e  mul_operator_i,
  input  ex_pkg::word_t    mul_operand_a_i,
  input  ex_pkg::word_t    mul_operand_b_i,
  input  logic             rf_we_i,
  input  ex_pkg::rf_addr_t rf_waddr_i,
  input  ex_pkg::word_t    pc_i,
  input  logic             alu_bch_i,
  input  logic             alu_jmp_i,

  // From the controller
  input  logic             kill_ex_i,
  input  logic             halt_ex_i,

  // Stage handshake
  input  logic             wb_ready_i,
  output logic             ex_ready_o,
  output logic             ex_valid_o,

  // Branch decision and forwarding value
  output logic             branch_decision_o,
  output ex_pkg::word_t    rf_wdata_o,

  // Registered write-back outputs
  output logic             wb_instr_valid_o,
  output logic             wb_rf_we_o,
  output ex_pkg::rf_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t    wb_rf_wdata_o,
  output ex_pkg::word_t    wb_pc_o,
  output logic             wb_bch_taken_o,
  output logic             wb_jmp_o
);

  // Gated valid and unit handshakes
  logic          instr_valid;
  logic          mul_valid_in;
  logic          mul_ready;
  logic          mul_valid;

  // Unit results
  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::word_t mul_result;

  // Control flow flags qualified by the ALU enable
  logic          bch_qual;
  logic          jmp_qual;

  // Neither killed nor halted
  assign instr_valid  = instr_valid_i && !kill_ex_i && !halt_ex_i;
  // Kill or halt drops the multiplier back to idle
  assign mul_valid_in = mul_en_i && instr_valid;

  // Forwarding mux, also feeds the WB register
  assign rf_wdata_o        = mul_en_i ? mul_result : alu_result;
  assign branch_decision_o = alu_cmp_result;

  assign bch_qual = alu_bch_i && alu_en_i;
  assign jmp_qual = alu_jmp_i && alu_en_i;

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // ALU is always done in one cycle, multiply waits for its unit
  assign ex_valid_o = instr_valid && (alu_en_i || (mul_en_i && mul_valid));
  // Kill frees the stage at once, halt blocks it
  assign ex_ready_o = kill_ex_i || (wb_ready_i && mul_ready && !halt_ex_i);

  //////////////////////////////////////////////////
  // Functional units and EX/WB register
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_operator_i),
    .op_a_i     (mul_operand_a_i),
    .op_b_i     (mul_operand_b_i),
    .valid_i    (mul_valid_in),
    .ready_i    (wb_ready_i),
    .result_o   (mul_result),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid)
  );

  ex_wb_reg u_wb_reg (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid_i        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .rf_we_i           (rf_we_i),
    .rf_waddr_i        (rf_waddr_i),
    .rf_wdata_i        (rf_wdata_o),
    .pc_i              (pc_i),
    .bch_i             (bch_qual),
    .jmp_i             (jmp_qual),
    .branch_decision_i (branch_decision_o),
    .wb_instr_valid_o  (wb_instr_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o),
    .wb_pc_o           (wb_pc_o),
    .wb_bch_taken_o    (wb_bch_taken_o),
    .wb_jmp_o          (wb_jmp_o)
  );

endmodule

//--- hw/ex_wb_reg.sv
//////////////////////////////////////////////////
// EX/WB pipeline register
// Transfer on valid and ready, bubble when empty
// Holds every output under back-pressure
//////////////////////////////////////////////////

module ex_wb_reg (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ex_valid_i,
  input  logic             wb_ready_i,
  input  logic             rf_we_i,
  input  ex_pkg::rf_addr_t rf_waddr_i,
  input  ex_pkg::word_t    rf_wdata_i,
  input  ex_pkg::word_t    pc_i,
  input  logic             bch_i,
  input  logic             jmp_i,
  input  logic             branch_decision_i,
  output logic             wb_instr_valid_o,
  output logic             wb_rf_we_o,
  output ex_pkg::rf_addr_t wb_rf_waddr_o,
  output ex_pkg::word_t    wb_rf_wdata_o,
  output ex_pkg::word_t    wb_pc_o,
  output logic             wb_bch_taken_o,
  output logic             wb_jmp_o
);

  logic transfer;
  logic bubble;

  // Instruction moves to WB
  assign transfer = ex_valid_i && wb_ready_i;
  // WB is free but EX has nothing to give
  assign bubble   = !ex_valid_i && wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_instr_valid_o <= 1'b0;
      wb_rf_we_o       <= 1'b0;
      wb_rf_waddr_o    <= '0;
      wb_rf_wdata_o    <= '0;
      wb_pc_o          <= '0;
      wb_bch_taken_o   <= 1'b0;
      wb_jmp_o         <= 1'b0;
    end else if (transfer) begin
      wb_instr_valid_o <= 1'b1;
      wb_rf_we_o       <= rf_we_i;
      // Write address and data only move with a write
      if (rf_we_i) begin
        wb_rf_waddr_o <= rf_waddr_i;
        wb_rf_wdata_o <= rf_wdata_i;
      end
      wb_pc_o        <= pc_i;
      // Taken only for a branch whose compare passed
      wb_bch_taken_o <= bch_i && branch_decision_i;
      wb_jmp_o       <= jmp_i;
    end else if (bubble) begin
      // Empty slot, no write and no control flow change
      wb_instr_valid_o <= 1'b0;
      wb_rf_we_o       <= 1'b0;
      wb_bch_taken_o   <= 1'b0;
      wb_jmp_o         <= 1'b0;
    end
    // wb_ready_i low: everything holds
  end

endmodule

//--- verif/ex_stage_assert.sv
//////////////////////////////////////////////////
// Bound checker for the execute stage
// Kill/valid rule, WB hold under back-pressure
// WB register state after reset
//////////////////////////////////////////////////

module ex_stage_assert (
  input logic             clk,
  input logic             rst_n,
  input logic             kill_ex_i,
  input logic             ex_valid_o,
  input logic             wb_ready_i,
  input logic             wb_instr_valid_o,
  input logic             wb_rf_we_o,
  input ex_pkg::rf_addr_t wb_rf_waddr_o,
  input ex_pkg::word_t    wb_rf_wdata_o,
  input ex_pkg::word_t    wb_pc_o,
  input logic             wb_bch_taken_o,
  input logic             wb_jmp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failure count, read by the testbench
  int fails = 0;

  // A killed instruction is never valid
  kill_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
      kill_ex_i |-> !ex_valid_o)
    else begin
      fails++;
      $error("ex_valid_o high while kill_ex_i is high");
    end

  // WB holds for a cycle with wb_ready_i low
  wb_holds_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
      !wb_ready_i |=> $stable(wb_instr_valid_o) && $stable(wb_rf_we_o) &&
        $stable(wb_rf_waddr_o) && $stable(wb_rf_wdata_o) && $stable(wb_pc_o) &&
        $stable(wb_bch_taken_o) && $stable(wb_jmp_o))
    else begin
      fails++;
      $error("WB outputs changed while wb_ready_i was low");
    end

  // WB register comes out of reset empty
  wb_empty_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !wb_instr_valid_o)
    else begin
      fails++;
      $error("wb_instr_valid_o high after reset");
    end

endmodule

bind ex_stage ex_stage_assert u_assert (.*);

//--- verif/ex_stage_tb.sv
//////////////////////////////////////////////////
// Testbench for the execute stage
// Clock, reset, stimulus with back-pressure, kill and halt
// Reference model, write-back monitor and watchdog
//////////////////////////////////////////////////

module ex_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 10;
  localparam int          MAX_STALL    = 3;
  localparam int unsigned SEED         = 32'h7fe8_1408;
  localparam int          N_ALU        = 32;
  localparam int          N_BRANCH     = 24;
  localparam int          N_CORNER     = 16;
  localparam int          N_MUL        = 24;
  localparam int          N_MIXED      = 40;
  localparam int          N_CTRL       = 6;
  localparam int          N_INSTR      = N_ALU + N_BRANCH + N_CORNER + N_MUL + N_MIXED + N_CTRL;

  // Expected write-back record
  typedef struct packed {
    ex_pkg::rf_addr_t waddr;
    ex_pkg::word_t    wdata;
    ex_pkg::word_t    pc;
    logic             bch_taken;
    logic             jmp;
  } wb_rec_t;

  logic             clk;
  logic             rst_n;
  logic             instr_valid_i;
  logic             alu_en_i;
  logic             mul_en_i;
  ex_pkg::alu_op_e  alu_operator_i;
  ex_pkg::word_t    alu_operand_a_i;
  ex_pkg::word_t    alu_operand_b_i;
  ex_pkg::mul_op_e  mul_operator_i;
  ex_pkg::word_t    mul_operand_a_i;
  ex_pkg::word_t    mul_operand_b_i;
  logic             rf_we_i;
  ex_pkg::rf_addr_t rf_waddr_i;
  ex_pkg::word_t    pc_i;
  logic             alu_bch_i;
  logic             alu_jmp_i;
  logic             kill_ex_i;
  logic             halt_ex_i;
  logic             wb_ready_i;
  logic             ex_ready_o;
  logic             ex_valid_o;
  logic             branch_decision_o;
  ex_pkg::word_t    rf_wdata_o;
  logic             wb_instr_valid_o;
  logic             wb_rf_we_o;
  ex_pkg::rf_addr_t wb_rf_waddr_o;
  ex_pkg::word_t    wb_rf_wdata_o;
  ex_pkg::word_t    wb_pc_o;
  logic             wb_bch_taken_o;
  logic             wb_jmp_o;

  // Scoreboard and bookkeeping
  wb_rec_t       exp_q[$];
  int            check_errors = 0;
  int            other_errors = 0;
  logic          bp_en = 1'b0;
  int            low_run = 0;
  ex_pkg::word_t next_pc = 32'h0000_1000;

  ex_stage dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic compare_flag(ex_pkg::alu_op_e op, ex_pkg::word_t a, ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_EQ:                    return a == b;
      ex_pkg::ALU_NE:                    return a != b;
      ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:                    return $signed(a) >= $signed(b);
      ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU:                   return a >= b;
      default:                           return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::word_t model_result(logic is_mul, ex_pkg::alu_op_e aop,
                                                 ex_pkg::mul_op_e mop, ex_pkg::word_t a,
                                                 ex_pkg::word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    if (is_mul) begin
      // Extend by operator signedness, product modulo 2^64
      ax   = (mop == ex_pkg::MUL_MULH || mop == ex_pkg::MUL_MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
      bx   = (mop == ex_pkg::MUL_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
      prod = ax * bx;
      return (mop == ex_pkg::MUL_MUL) ? prod[31:0] : prod[63:32];
    end
    case (aop)
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: return {31'b0, compare_flag(aop, a, b)};
      // ADD and branch operators
      default:          return a + b;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string what, input ex_pkg::word_t got, input ex_pkg::word_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
      check_errors++;
    end
  endtask

  task automatic check_addr(input string what, input ex_pkg::rf_addr_t got,
                            input ex_pkg::rf_addr_t want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
      check_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
      check_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Random WB stalls, never longer than MAX_STALL cycles
  task automatic drive_backpressure();
    if (bp_en && low_run < MAX_STALL && $urandom_range(2, 0) == 0) begin
      wb_ready_i = 1'b0;
      low_run++;
    end else begin
      wb_ready_i = 1'b1;
      low_run    = 0;
    end
  endtask

  task automatic go_idle();
    instr_valid_i = 1'b0;
    alu_en_i      = 1'b0;
    mul_en_i      = 1'b0;
    alu_bch_i     = 1'b0;
    alu_jmp_i     = 1'b0;
    kill_ex_i     = 1'b0;
    halt_ex_i     = 1'b0;
    wb_ready_i    = 1'b1;
  endtask

  // Present one instruction at a falling edge and hold it until retired
  task automatic issue(input logic is_mul, input ex_pkg::alu_op_e aop, input ex_pkg::mul_op_e mop,
                       input ex_pkg::word_t a, input ex_pkg::word_t b, input logic bch,
                       input logic jmp, input int halt_cycles, input int kill_at);
    wb_rec_t rec;
    int      cyc;
    logic    retired;
    cyc             = 0;
    retired         = 1'b0;
    instr_valid_i   = 1'b1;
    alu_en_i        = !is_mul;
    mul_en_i        = is_mul;
    alu_operator_i  = aop;
    mul_operator_i  = mop;
    alu_operand_a_i = a;
    alu_operand_b_i = b;
    mul_operand_a_i = a;
    mul_operand_b_i = b;
    alu_bch_i       = bch;
    alu_jmp_i       = jmp;
    rf_we_i         = 1'b1;
    rf_waddr_i      = ex_pkg::rf_addr_t'($urandom());
    pc_i            = next_pc;
    next_pc         = next_pc + 4;
    rec.waddr       = rf_waddr_i;
    rec.wdata       = model_result(is_mul, aop, mop, a, b);
    rec.pc          = pc_i;
    rec.bch_taken   = bch && !is_mul && compare_flag(aop, a, b);
    rec.jmp         = jmp && !is_mul;
    while (!retired) begin
      halt_ex_i = (cyc < halt_cycles);
      kill_ex_i = (cyc == kill_at);
      drive_backpressure();
      // Mid-cycle, all inputs settled
      #(CLK_PERIOD / 4);
      if (halt_ex_i) check_flag("ex_ready_o under halt", ex_ready_o, 1'b0);
      if (is_mul && cyc == 0) check_flag("ex_ready_o on multiply start", ex_ready_o, kill_ex_i);
      if (bch && !is_mul) check_flag("branch_decision_o", branch_decision_o, compare_flag(aop, a, b));
      if (ex_ready_o) begin
        retired = 1'b1;
        // Killed instructions must never reach WB
        if (!kill_ex_i) begin
          // Stage offers the final forwarding value as it retires
          check_flag("ex_valid_o on retire", ex_valid_o, 1'b1);
          check_word("rf_wdata_o", rf_wdata_o, rec.wdata);
          exp_q.push_back(rec);
        end
      end
      @(negedge clk);
      cyc++;
    end
    kill_ex_i = 1'b0;
    halt_ex_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Write-back monitor
  //////////////////////////////////////////////////

  initial begin : wb_monitor
    logic    loaded;
    wb_rec_t want;
    loaded = 1'b0;
    forever begin
      @(negedge clk);
      // WB took a new entry at the last rising edge
      if (loaded && wb_instr_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("At %0t an instruction reached write-back that was never issued", $time);
          other_errors++;
        end else begin
          want = exp_q.pop_front();
          check_flag("wb_rf_we_o", wb_rf_we_o, 1'b1);
          check_addr("wb_rf_waddr_o", wb_rf_waddr_o, want.waddr);
          check_word("wb_rf_wdata_o", wb_rf_wdata_o, want.wdata);
          check_word("wb_pc_o", wb_pc_o, want.pc);
          check_flag("wb_bch_taken_o", wb_bch_taken_o, want.bch_taken);
          check_flag("wb_jmp_o", wb_jmp_o, want.jmp);
        end
      end
      #(CLK_PERIOD / 4);
      loaded = rst_n && wb_ready_i;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    int            i;
    int            total;
    ex_pkg::word_t a;
    ex_pkg::word_t corner [2];
    void'($urandom(SEED));
    corner[0]       = 32'h8000_0000;
    corner[1]       = 32'hffff_ffff;
    rst_n           = 1'b0;
    alu_operator_i  = ex_pkg::ALU_ADD;
    mul_operator_i  = ex_pkg::MUL_MUL;
    alu_operand_a_i = '0;
    alu_operand_b_i = '0;
    mul_operand_a_i = '0;
    mul_operand_b_i = '0;
    rf_we_i         = 1'b0;
    rf_waddr_i      = '0;
    pc_i            = '0;
    go_idle();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Reset values of the WB register
    check_flag("wb_instr_valid_o after reset", wb_instr_valid_o, 1'b0);
    check_flag("wb_rf_we_o after reset", wb_rf_we_o, 1'b0);
    check_flag("wb_bch_taken_o after reset", wb_bch_taken_o, 1'b0);
    check_flag("wb_jmp_o after reset", wb_jmp_o, 1'b0);
    check_addr("wb_rf_waddr_o after reset", wb_rf_waddr_o, '0);
    check_word("wb_rf_wdata_o after reset", wb_rf_wdata_o, '0);
    check_word("wb_pc_o after reset", wb_pc_o, '0);

    // Every ALU operator twice
    for (i = 0; i < N_ALU; i++) begin
      issue(1'b0, ex_pkg::alu_op_e'(i % 16), ex_pkg::MUL_MUL, $urandom(), $urandom(),
            1'b0, 1'b0, 0, -1);
    end

    // Branches with equal operands now and then, every fourth a jump
    for (i = 0; i < N_BRANCH; i++) begin
      a = $urandom();
      if (i % 4 == 3)
        issue(1'b0, ex_pkg::ALU_ADD, ex_pkg::MUL_MUL, a, $urandom(), 1'b0, 1'b1, 0, -1);
      else
        issue(1'b0, ex_pkg::alu_op_e'(10 + i % 6), ex_pkg::MUL_MUL, a,
              ($urandom_range(3, 0) == 0) ? a : $urandom(), 1'b1, 1'b0, 0, -1);
    end

    // Most negative and minus one for every multiply operator
    for (i = 0; i < N_CORNER; i++) begin
      issue(1'b1, ex_pkg::ALU_ADD, ex_pkg::mul_op_e'(i / 4), corner[i % 2], corner[(i / 2) % 2],
            1'b0, 1'b0, 0, -1);
    end
    for (i = 0; i < N_MUL; i++) begin
      issue(1'b1, ex_pkg::ALU_ADD, ex_pkg::mul_op_e'(i % 4), $urandom(), $urandom(),
            1'b0, 1'b0, 0, -1);
    end

    // Mixed traffic under random back-pressure
    bp_en = 1'b1;
    for (i = 0; i < N_MIXED; i++) begin
      issue(1'(($urandom_range(1, 0))), ex_pkg::alu_op_e'($urandom_range(15, 0)),
            ex_pkg::mul_op_e'($urandom_range(3, 0)), $urandom(), $urandom(),
            1'b0, 1'b0, 0, -1);
    end
    bp_en = 1'b0;

    // Kill an ALU op at once and a multiply in progress, then halt both kinds
    issue(1'b0, ex_pkg::ALU_XOR, ex_pkg::MUL_MUL, $urandom(), $urandom(), 1'b0, 1'b0, 0, 0);
    issue(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_MULH, $urandom(), $urandom(), 1'b0, 1'b0, 0, 2);
    issue(1'b0, ex_pkg::ALU_SUB, ex_pkg::MUL_MUL, $urandom(), $urandom(), 1'b0, 1'b0, 3, -1);
    issue(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_MULHSU, $urandom(), $urandom(), 1'b0, 1'b0, 3, -1);
    issue(1'b0, ex_pkg::ALU_OR, ex_pkg::MUL_MUL, $urandom(), $urandom(), 1'b0, 1'b0, 0, -1);
    issue(1'b1, ex_pkg::ALU_ADD, ex_pkg::MUL_MULHU, $urandom(), $urandom(), 1'b0, 1'b0, 0, -1);

    // Drain the pipeline
    go_idle();
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d issued instructions never reached write-back", exp_q.size());
      other_errors++;
    end

    total = check_errors + other_errors + dut.u_assert.fails;
    $display("Error counts: %0d value mismatches, %0d lost or extra records, %0d assertion failures",
             check_errors, other_errors, dut.u_assert.fails);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Worst case per instruction covers a multiply plus a full stall
  initial begin : watchdog
    #((RESET_CYCLES + 10 + N_INSTR * (ex_pkg::MUL_STEPS + MAX_STALL + 4)) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the allowed simulation time");
    $display("Errors found");
    $finish;
  end

endmodule
